// ==== src/gpu_pkg.sv ====
package gpu_pkg;

    // datapath widths
    localparam int DATA_WIDTH = 32;
    localparam int IMEM_ADDR_WIDTH = 8;
    localparam int DMEM_ADDR_WIDTH = 8;
    // 16 registers per thread
    localparam int REG_ADDR_WIDTH = 4;
    localparam int IMM_WIDTH = 16;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [IMEM_ADDR_WIDTH-1:0] imem_addr_t;
    typedef logic [DMEM_ADDR_WIDTH-1:0] dmem_addr_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    // top nibble of every instruction word
    typedef enum logic [3:0] {
        ADD = 4'h0,
        SUB = 4'h1,
        AND = 4'h2,
        OR = 4'h3,
        XOR = 4'h4,
        ADDI = 4'h5,
        LI = 4'h6,
        TID = 4'h7,
        STORE = 4'h8,
        HALT = 4'h9
    } opcode_t;

    // same 32 bits, decoded as register form or immediate form
    // for STORE, rd holds the data register
    typedef union packed {
        struct packed {
            opcode_t opcode;
            reg_addr_t rd;
            reg_addr_t rs1;
            reg_addr_t rs2;
            logic [15:0] unused;
        } r_form;
        struct packed {
            opcode_t opcode;
            reg_addr_t rd;
            reg_addr_t rs1;
            logic [3:0] unused;
            logic [IMM_WIDTH-1:0] imm;
        } i_form;
    } instruction_t;

    // per-warp lifecycle
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        REQUEST,
        WAIT,
        EXECUTE,
        UPDATE,
        DONE
    } warp_state_t;

endpackage

// ==== src/imem_if.sv ====
`timescale 1ns/1ps

// one warp's instruction read channel
interface imem_if;
    logic valid;
    logic ready;
    gpu_pkg::imem_addr_t address;
    gpu_pkg::instruction_t data;

    // valid and address held until ready, data taken in that cycle
    modport fetcher (output valid, output address, input ready, input data);
    modport memory (input valid, input address, output ready, output data);
endinterface

// ==== src/exec_if.sv ====
`timescale 1ns/1ps

// decoded fields of the warp in flight
interface exec_if;
    gpu_pkg::opcode_t op;
    gpu_pkg::reg_addr_t rd;
    gpu_pkg::reg_addr_t rs1;
    gpu_pkg::reg_addr_t rs2;
    // already sign extended
    gpu_pkg::data_t imm;
    logic reg_write;
    logic mem_write;
    logic halt;

    modport decoder (
        output op, output rd, output rs1, output rs2, output imm,
        output reg_write, output mem_write, output halt
    );
    modport reader (
        input op, input rd, input rs1, input rs2, input imm,
        input reg_write, input mem_write
    );
    // scheduler only needs to know whether to stop the warp
    modport scheduler (input halt);
endinterface

// ==== src/fetcher.sv ====
`timescale 1ns/1ps

module fetcher (
    input logic clk,
    input logic reset,
    input logic fetch_req,
    input gpu_pkg::imem_addr_t pc,
    imem_if.fetcher mem,
    output logic fetch_done,
    output gpu_pkg::instruction_t instruction
);

    always_ff @(posedge clk) begin
        if (reset) begin
            mem.valid <= 1'b0;
            fetch_done <= 1'b0;
        end else if (!fetch_req) begin
            // warp left FETCH, arm for the next one
            mem.valid <= 1'b0;
            fetch_done <= 1'b0;
        end else if (mem.valid && mem.ready) begin
            mem.valid <= 1'b0;
            fetch_done <= 1'b1;
            instruction <= mem.data;
        end else if (!mem.valid && !fetch_done) begin
            // single request per FETCH phase
            mem.valid <= 1'b1;
            mem.address <= pc;
        end
    end

endmodule

// ==== src/decoder.sv ====
`timescale 1ns/1ps

module decoder #(
    parameter int WARPS_PER_CORE = 2,
    localparam int WARP_INDEX_WIDTH = (WARPS_PER_CORE > 1) ? $clog2(WARPS_PER_CORE) : 1
) (
    input logic clk,
    input logic reset,
    input logic decode_strobe,
    input logic [WARP_INDEX_WIDTH-1:0] current_warp,
    input gpu_pkg::instruction_t instructions [WARPS_PER_CORE],
    exec_if.decoder exec
);

    gpu_pkg::instruction_t word;

    assign word = instructions[current_warp];

    always_ff @(posedge clk) begin
        if (reset) begin
            exec.reg_write <= 1'b0;
            exec.mem_write <= 1'b0;
            exec.halt <= 1'b0;
        end else if (decode_strobe) begin
            exec.op <= word.r_form.opcode;
            exec.rd <= word.r_form.rd;
            exec.rs1 <= word.r_form.rs1;
            // rs2 only meaningful in register form
            exec.rs2 <= word.r_form.rs2;
            exec.imm <= gpu_pkg::data_t'(signed'(word.i_form.imm));
            // everything but STORE and HALT writes back
            exec.reg_write <= !(word.r_form.opcode inside {gpu_pkg::STORE, gpu_pkg::HALT});
            exec.mem_write <= (word.r_form.opcode == gpu_pkg::STORE);
            exec.halt <= (word.r_form.opcode == gpu_pkg::HALT);
        end
    end

endmodule

// ==== src/vector_reg_file.sv ====
`timescale 1ns/1ps

module vector_reg_file #(
    parameter int WARPS_PER_CORE = 2,
    parameter int THREADS_PER_WARP = 4,
    localparam int WARP_INDEX_WIDTH = (WARPS_PER_CORE > 1) ? $clog2(WARPS_PER_CORE) : 1,
    localparam int NUM_REGS = 2 ** gpu_pkg::REG_ADDR_WIDTH
) (
    input logic clk,
    input logic reset,
    input logic [WARP_INDEX_WIDTH-1:0] current_warp,
    input logic execute_strobe,
    exec_if.reader exec,
    input gpu_pkg::data_t lane_result [THREADS_PER_WARP],
    output gpu_pkg::data_t rs1_data [THREADS_PER_WARP],
    output gpu_pkg::data_t rs2_data [THREADS_PER_WARP],
    output gpu_pkg::data_t rd_data [THREADS_PER_WARP]
);

    // warp x thread x register
    gpu_pkg::data_t regs [WARPS_PER_CORE][THREADS_PER_WARP][NUM_REGS];

    for (genvar t = 0; t < THREADS_PER_WARP; t++) begin : g_read
        assign rs1_data[t] = regs[current_warp][t][exec.rs1];
        assign rs2_data[t] = regs[current_warp][t][exec.rs2];
        // store data comes through rd
        assign rd_data[t] = regs[current_warp][t][exec.rd];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < WARPS_PER_CORE; w++) begin
                for (int t = 0; t < THREADS_PER_WARP; t++) begin
                    for (int r = 0; r < NUM_REGS; r++) begin
                        regs[w][t][r] <= '0;
                    end
                end
            end
        end else if (execute_strobe && exec.reg_write) begin
            // every lane active
            for (int t = 0; t < THREADS_PER_WARP; t++) begin
                regs[current_warp][t][exec.rd] <= lane_result[t];
            end
        end
    end

endmodule

// ==== src/lane_datapath.sv ====
`timescale 1ns/1ps

module lane_datapath #(
    parameter int WARPS_PER_CORE = 2,
    parameter int THREADS_PER_WARP = 4,
    localparam int WARP_INDEX_WIDTH = (WARPS_PER_CORE > 1) ? $clog2(WARPS_PER_CORE) : 1
) (
    input logic clk,
    input logic reset,
    input logic [WARP_INDEX_WIDTH-1:0] current_warp,
    input logic issue_strobe,
    exec_if.reader exec,
    input gpu_pkg::data_t rs1_data [THREADS_PER_WARP],
    input gpu_pkg::data_t rs2_data [THREADS_PER_WARP],
    input gpu_pkg::data_t rd_data [THREADS_PER_WARP],
    output gpu_pkg::data_t lane_result [THREADS_PER_WARP],
    output logic lanes_busy,
    output logic dmem_write_valid [THREADS_PER_WARP],
    output gpu_pkg::dmem_addr_t dmem_write_address [THREADS_PER_WARP],
    output gpu_pkg::data_t dmem_write_data [THREADS_PER_WARP],
    input logic dmem_write_ready [THREADS_PER_WARP]
);

    // store still waiting for ready, per lane
    logic [THREADS_PER_WARP-1:0] pending;

    assign lanes_busy = |pending;

    for (genvar l = 0; l < THREADS_PER_WARP; l++) begin : g_lane
        gpu_pkg::data_t store_address;
        gpu_pkg::data_t thread_id;

        // global thread index
        assign thread_id = gpu_pkg::data_t'(current_warp) * gpu_pkg::data_t'(THREADS_PER_WARP)
                           + gpu_pkg::data_t'(l);
        assign store_address = rs1_data[l] + exec.imm;
        assign dmem_write_valid[l] = pending[l];

        always_comb begin
            case (exec.op)
                gpu_pkg::ADD: lane_result[l] = rs1_data[l] + rs2_data[l];
                gpu_pkg::SUB: lane_result[l] = rs1_data[l] - rs2_data[l];
                gpu_pkg::AND: lane_result[l] = rs1_data[l] & rs2_data[l];
                gpu_pkg::OR: lane_result[l] = rs1_data[l] | rs2_data[l];
                gpu_pkg::XOR: lane_result[l] = rs1_data[l] ^ rs2_data[l];
                gpu_pkg::ADDI: lane_result[l] = rs1_data[l] + exec.imm;
                gpu_pkg::LI: lane_result[l] = exec.imm;
                gpu_pkg::TID: lane_result[l] = thread_id;
                // STORE and HALT write nothing back
                default: lane_result[l] = '0;
            endcase
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                pending[l] <= 1'b0;
            end else if (issue_strobe && exec.mem_write) begin
                pending[l] <= 1'b1;
                // low bits of rs1 + imm address the data memory
                dmem_write_address[l] <= store_address[gpu_pkg::DMEM_ADDR_WIDTH-1:0];
                dmem_write_data[l] <= rd_data[l];
            end else if (pending[l] && dmem_write_ready[l]) begin
                pending[l] <= 1'b0;
            end
        end
    end

endmodule

// ==== src/warp_scheduler.sv ====
`timescale 1ns/1ps

module warp_scheduler #(
    parameter int WARPS_PER_CORE = 2,
    localparam int WARP_INDEX_WIDTH = (WARPS_PER_CORE > 1) ? $clog2(WARPS_PER_CORE) : 1,
    localparam int WARP_COUNT_WIDTH = $clog2(WARPS_PER_CORE + 1)
) (
    input logic clk,
    input logic reset,
    input logic start,
    input gpu_pkg::imem_addr_t base_pc,
    input logic [WARP_COUNT_WIDTH-1:0] num_warps,
    input logic [WARPS_PER_CORE-1:0] fetch_done,
    input logic lanes_busy,
    exec_if.scheduler exec,
    output gpu_pkg::imem_addr_t warp_pc [WARPS_PER_CORE],
    output logic [WARPS_PER_CORE-1:0] fetch_req,
    output logic [WARP_INDEX_WIDTH-1:0] current_warp,
    output logic decode_strobe,
    output logic issue_strobe,
    output logic execute_strobe,
    output logic done
);

    gpu_pkg::warp_state_t state [WARPS_PER_CORE];
    // kernel launched, later start pulses ignored
    logic running;
    // current_warp picked and sitting its one DECODE cycle
    logic selected;
    logic in_flight;
    logic all_done;
    logic pick_valid;
    logic [WARP_INDEX_WIDTH-1:0] pick;

    always_comb begin
        int idx;
        in_flight = selected;
        all_done = running;
        pick_valid = 1'b0;
        pick = current_warp;
        for (int w = 0; w < WARPS_PER_CORE; w++) begin
            fetch_req[w] = (state[w] == gpu_pkg::FETCH);
            if (state[w] inside {gpu_pkg::REQUEST, gpu_pkg::WAIT,
                                 gpu_pkg::EXECUTE, gpu_pkg::UPDATE}) begin
                in_flight = 1'b1;
            end
            // unconfigured warps never count
            if (w < num_warps && state[w] != gpu_pkg::DONE) begin
                all_done = 1'b0;
            end
        end
        // scan downward so the nearest decode warp after the last pick wins
        for (int i = WARPS_PER_CORE; i >= 1; i--) begin
            idx = (int'(current_warp) + i) % WARPS_PER_CORE;
            if (state[idx] == gpu_pkg::DECODE) begin
                pick_valid = 1'b1;
                pick = WARP_INDEX_WIDTH'(idx);
            end
        end
    end

    // one-cycle strobes for the warp in flight
    assign decode_strobe = selected;
    assign issue_strobe = (state[current_warp] == gpu_pkg::REQUEST);
    assign execute_strobe = (state[current_warp] == gpu_pkg::EXECUTE);

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            selected <= 1'b0;
            done <= 1'b0;
            // first pick lands on warp 0
            current_warp <= WARP_INDEX_WIDTH'(WARPS_PER_CORE - 1);
            for (int w = 0; w < WARPS_PER_CORE; w++) begin
                state[w] <= gpu_pkg::IDLE;
                warp_pc[w] <= '0;
            end
        end else begin
            // sticky until reset
            done <= done | all_done;
            if (start && !running) begin
                running <= 1'b1;
                for (int w = 0; w < WARPS_PER_CORE; w++) begin
                    if (w < num_warps) begin
                        state[w] <= gpu_pkg::FETCH;
                        warp_pc[w] <= base_pc;
                    end
                end
            end
            // fetches finish in parallel
            for (int w = 0; w < WARPS_PER_CORE; w++) begin
                if (state[w] == gpu_pkg::FETCH && fetch_done[w]) begin
                    state[w] <= gpu_pkg::DECODE;
                end
            end
            if (selected) begin
                selected <= 1'b0;
                state[current_warp] <= gpu_pkg::REQUEST;
            end else if (!in_flight && pick_valid) begin
                selected <= 1'b1;
                current_warp <= pick;
            end
            case (state[current_warp])
                gpu_pkg::REQUEST: state[current_warp] <= gpu_pkg::WAIT;
                gpu_pkg::WAIT: begin
                    // stores must drain first
                    if (!lanes_busy) begin
                        state[current_warp] <= gpu_pkg::EXECUTE;
                    end
                end
                gpu_pkg::EXECUTE: state[current_warp] <= gpu_pkg::UPDATE;
                gpu_pkg::UPDATE: begin
                    if (exec.halt) begin
                        state[current_warp] <= gpu_pkg::DONE;
                    end else begin
                        state[current_warp] <= gpu_pkg::FETCH;
                        warp_pc[current_warp] <= warp_pc[current_warp] + gpu_pkg::imem_addr_t'(1);
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== src/compute_core.sv ====
`timescale 1ns/1ps

module compute_core #(
    parameter int WARPS_PER_CORE = 2,
    parameter int THREADS_PER_WARP = 4,
    localparam int WARP_INDEX_WIDTH = (WARPS_PER_CORE > 1) ? $clog2(WARPS_PER_CORE) : 1,
    localparam int WARP_COUNT_WIDTH = $clog2(WARPS_PER_CORE + 1)
) (
    input logic clk,
    input logic reset,
    input logic start,
    input gpu_pkg::imem_addr_t base_pc,
    input logic [WARP_COUNT_WIDTH-1:0] num_warps,
    output logic done,

    // instruction memory, one channel per warp
    output logic imem_valid [WARPS_PER_CORE],
    output gpu_pkg::imem_addr_t imem_address [WARPS_PER_CORE],
    input logic imem_ready [WARPS_PER_CORE],
    input gpu_pkg::instruction_t imem_data [WARPS_PER_CORE],

    // data memory writes, one channel per lane
    output logic dmem_write_valid [THREADS_PER_WARP],
    output gpu_pkg::dmem_addr_t dmem_write_address [THREADS_PER_WARP],
    output gpu_pkg::data_t dmem_write_data [THREADS_PER_WARP],
    input logic dmem_write_ready [THREADS_PER_WARP]
);

    logic [WARPS_PER_CORE-1:0] fetch_req;
    logic [WARPS_PER_CORE-1:0] fetch_done;
    gpu_pkg::imem_addr_t warp_pc [WARPS_PER_CORE];
    gpu_pkg::instruction_t instructions [WARPS_PER_CORE];
    logic [WARP_INDEX_WIDTH-1:0] current_warp;
    logic decode_strobe;
    logic issue_strobe;
    logic execute_strobe;
    logic lanes_busy;
    gpu_pkg::data_t rs1_data [THREADS_PER_WARP];
    gpu_pkg::data_t rs2_data [THREADS_PER_WARP];
    gpu_pkg::data_t rd_data [THREADS_PER_WARP];
    gpu_pkg::data_t lane_result [THREADS_PER_WARP];

    exec_if exec_bus ();

    warp_scheduler #(.WARPS_PER_CORE(WARPS_PER_CORE)) scheduler (
        .clk(clk),
        .reset(reset),
        .start(start),
        .base_pc(base_pc),
        .num_warps(num_warps),
        .fetch_done(fetch_done),
        .lanes_busy(lanes_busy),
        .exec(exec_bus),
        .warp_pc(warp_pc),
        .fetch_req(fetch_req),
        .current_warp(current_warp),
        .decode_strobe(decode_strobe),
        .issue_strobe(issue_strobe),
        .execute_strobe(execute_strobe),
        .done(done)
    );

    // per-warp fetch path, fetches overlap with execution
    for (genvar w = 0; w < WARPS_PER_CORE; w++) begin : g_warp
        imem_if imem_bus ();

        assign imem_valid[w] = imem_bus.valid;
        assign imem_address[w] = imem_bus.address;
        assign imem_bus.ready = imem_ready[w];
        assign imem_bus.data = imem_data[w];

        fetcher fetch_unit (
            .clk(clk),
            .reset(reset),
            .fetch_req(fetch_req[w]),
            .pc(warp_pc[w]),
            .mem(imem_bus),
            .fetch_done(fetch_done[w]),
            .instruction(instructions[w])
        );
    end

    decoder #(.WARPS_PER_CORE(WARPS_PER_CORE)) decode_unit (
        .clk(clk),
        .reset(reset),
        .decode_strobe(decode_strobe),
        .current_warp(current_warp),
        .instructions(instructions),
        .exec(exec_bus)
    );

    vector_reg_file #(
        .WARPS_PER_CORE(WARPS_PER_CORE),
        .THREADS_PER_WARP(THREADS_PER_WARP)
    ) reg_file (
        .clk(clk),
        .reset(reset),
        .current_warp(current_warp),
        .execute_strobe(execute_strobe),
        .exec(exec_bus),
        .lane_result(lane_result),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .rd_data(rd_data)
    );

    lane_datapath #(
        .WARPS_PER_CORE(WARPS_PER_CORE),
        .THREADS_PER_WARP(THREADS_PER_WARP)
    ) lanes (
        .clk(clk),
        .reset(reset),
        .current_warp(current_warp),
        .issue_strobe(issue_strobe),
        .exec(exec_bus),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .rd_data(rd_data),
        .lane_result(lane_result),
        .lanes_busy(lanes_busy),
        .dmem_write_valid(dmem_write_valid),
        .dmem_write_address(dmem_write_address),
        .dmem_write_data(dmem_write_data),
        .dmem_write_ready(dmem_write_ready)
    );

endmodule

// ==== test/compute_core_asserts.sv ====
`timescale 1ns/1ps

module compute_core_asserts #(
    parameter int WARPS_PER_CORE = 2,
    parameter int THREADS_PER_WARP = 4
) (
    input logic clk,
    input logic reset,
    input logic done,
    input logic imem_valid [WARPS_PER_CORE],
    input gpu_pkg::imem_addr_t imem_address [WARPS_PER_CORE],
    input logic imem_ready [WARPS_PER_CORE],
    input logic dmem_write_valid [THREADS_PER_WARP],
    input gpu_pkg::dmem_addr_t dmem_write_address [THREADS_PER_WARP],
    input gpu_pkg::data_t dmem_write_data [THREADS_PER_WARP],
    input logic dmem_write_ready [THREADS_PER_WARP]
);

    // done is sticky until reset
    done_sticky: assert property (@(posedge clk) disable iff (reset) done |=> done)
        else $error("done fell without reset");

    for (genvar w = 0; w < WARPS_PER_CORE; w++) begin : g_imem
        // request held until the memory takes it
        imem_hold: assert property (@(posedge clk) disable iff (reset)
            imem_valid[w] && !imem_ready[w] |=> imem_valid[w] && $stable(imem_address[w]))
            else $error("instruction request of warp %0d changed before ready", w);
        imem_quiet: assert property (@(posedge clk) disable iff (reset)
            done |-> !imem_valid[w])
            else $error("instruction request of warp %0d while done", w);
    end

    for (genvar l = 0; l < THREADS_PER_WARP; l++) begin : g_dmem
        dmem_hold: assert property (@(posedge clk) disable iff (reset)
            dmem_write_valid[l] && !dmem_write_ready[l] |=> dmem_write_valid[l]
                && $stable(dmem_write_address[l]) && $stable(dmem_write_data[l]))
            else $error("store of lane %0d changed before ready", l);
        dmem_quiet: assert property (@(posedge clk) disable iff (reset)
            done |-> !dmem_write_valid[l])
            else $error("store of lane %0d while done", l);
    end

endmodule

bind compute_core compute_core_asserts #(
    .WARPS_PER_CORE(WARPS_PER_CORE),
    .THREADS_PER_WARP(THREADS_PER_WARP)
) asserts0 (
    .clk(clk),
    .reset(reset),
    .done(done),
    .imem_valid(imem_valid),
    .imem_address(imem_address),
    .imem_ready(imem_ready),
    .dmem_write_valid(dmem_write_valid),
    .dmem_write_address(dmem_write_address),
    .dmem_write_data(dmem_write_data),
    .dmem_write_ready(dmem_write_ready)
);

// ==== test/tb_compute_core.sv ====
`timescale 1ns/1ps

module tb_compute_core;

    localparam int WARPS = 2;
    localparam int THREADS = 4;
    localparam int IMEM_DEPTH = 256;
    localparam int COIN_COUNT = 1024;
    localparam int CYCLES_PER_LINE = 200;

    logic clk;
    logic reset;
    logic start;
    gpu_pkg::imem_addr_t base_pc;
    logic [1:0] num_warps;
    logic done;
    logic imem_valid [WARPS];
    gpu_pkg::imem_addr_t imem_address [WARPS];
    logic imem_ready [WARPS];
    gpu_pkg::instruction_t imem_data [WARPS];
    logic dmem_write_valid [THREADS];
    gpu_pkg::dmem_addr_t dmem_write_address [THREADS];
    gpu_pkg::data_t dmem_write_data [THREADS];
    logic dmem_write_ready [THREADS];

    // per-warp program memory
    logic [31:0] imem_words [WARPS][IMEM_DEPTH];
    // sparse data memory, keyed by address
    gpu_pkg::data_t expected_words [int];
    gpu_pkg::data_t written_words [int];
    // ready coin flips, drawn after seeding
    bit ready_coin [COIN_COUNT];
    int cycle_count = 0;
    int cfg_warps = 0;
    gpu_pkg::imem_addr_t cfg_pc;
    int mismatch_count = 0;
    int failure_count = 0;
    bit stray_fetch_seen;
    bit done_seen;
    // handshake tracking in the memory models
    bit imem_waiting [WARPS];
    gpu_pkg::imem_addr_t imem_held [WARPS];
    bit dmem_waiting [THREADS];
    gpu_pkg::dmem_addr_t dmem_held_address [THREADS];
    gpu_pkg::data_t dmem_held_data [THREADS];
    // records parsed from the test file
    byte tags [$];
    logic [31:0] field_a [$];
    logic [31:0] field_b [$];
    logic [31:0] field_c [$];

    compute_core dut0 (
        .clk(clk),
        .reset(reset),
        .start(start),
        .base_pc(base_pc),
        .num_warps(num_warps),
        .done(done),
        .imem_valid(imem_valid),
        .imem_address(imem_address),
        .imem_ready(imem_ready),
        .imem_data(imem_data),
        .dmem_write_valid(dmem_write_valid),
        .dmem_write_address(dmem_write_address),
        .dmem_write_data(dmem_write_data),
        .dmem_write_ready(dmem_write_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        failure_count++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // one accepted store, checked against the expected words
    task automatic record_store(input int address, input gpu_pkg::data_t value);
        if (done) begin
            report_failure($sformatf("store to address %02h accepted after done", address));
        end
        if (written_words.exists(address)) begin
            report_failure($sformatf("data address %02h written a second time", address));
        end else if (!expected_words.exists(address)) begin
            report_failure($sformatf("store to unexpected data address %02h", address));
        end else if (value !== expected_words[address]) begin
            mismatch_count++;
            $display("mismatch at %0t: dmem_write_data for address %02h expected %08h got %08h",
                     $time, address, expected_words[address], value);
        end
        written_words[address] = value;
    endtask

    task automatic clear_memories();
        for (int w = 0; w < WARPS; w++) begin
            for (int a = 0; a < IMEM_DEPTH; a++) begin
                // HALT words tagged with warp and address
                imem_words[w][a] = 32'h9000_0000 | (w << 8) | a;
            end
        end
        expected_words.delete();
        written_words.delete();
        stray_fetch_seen = 1'b0;
    endtask

    task automatic run_test();
        @(posedge clk);
        reset <= 1'b1;
        start <= 1'b0;
        num_warps <= 2'(cfg_warps);
        base_pc <= cfg_pc;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        if (done) begin
            report_failure("done high before start");
        end
        for (int w = 0; w < WARPS; w++) begin
            if (imem_valid[w]) begin
                report_failure($sformatf("warp %0d fetching before start", w));
            end
        end
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (!done) begin
            @(posedge clk);
        end
        // quiet window, late fetches or stores would show here
        repeat (10) @(posedge clk);
        foreach (expected_words[a]) begin
            if (!written_words.exists(a)) begin
                report_failure($sformatf("no store reached data address %02h", a));
            end
        end
    endtask

    // cycle count and done stickiness
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (!reset && done_seen && !done) begin
            report_failure("done fell without reset");
        end
        done_seen <= done && !reset;
    end

    // instruction memory with random ready gaps
    always @(posedge clk) begin
        for (int w = 0; w < WARPS; w++) begin
            if (reset) begin
                imem_ready[w] <= 1'b0;
                imem_waiting[w] = 1'b0;
            end else begin
                if (imem_waiting[w] && (!imem_valid[w] || imem_address[w] != imem_held[w])) begin
                    report_failure($sformatf("warp %0d changed its fetch before ready", w));
                end
                if (imem_valid[w] && w >= cfg_warps && !stray_fetch_seen) begin
                    stray_fetch_seen = 1'b1;
                    report_failure($sformatf("unconfigured warp %0d fetched", w));
                end
                if (imem_valid[w] && done) begin
                    report_failure($sformatf("warp %0d fetching while done", w));
                end
                if (imem_valid[w] && imem_ready[w]) begin
                    imem_ready[w] <= 1'b0;
                    imem_waiting[w] = 1'b0;
                end else if (imem_valid[w]) begin
                    imem_ready[w] <= ready_coin[(cycle_count + 97 * w) % COIN_COUNT];
                    // data from the held address, taken with ready
                    imem_data[w] <= imem_words[w][imem_address[w]];
                    imem_waiting[w] = 1'b1;
                    imem_held[w] = imem_address[w];
                end else begin
                    imem_ready[w] <= 1'b0;
                end
            end
        end
    end

    // data memory write side, same gap scheme per lane
    always @(posedge clk) begin
        for (int l = 0; l < THREADS; l++) begin
            if (reset) begin
                dmem_write_ready[l] <= 1'b0;
                dmem_waiting[l] = 1'b0;
            end else begin
                if (dmem_waiting[l] && (!dmem_write_valid[l]
                        || dmem_write_address[l] != dmem_held_address[l]
                        || dmem_write_data[l] != dmem_held_data[l])) begin
                    report_failure($sformatf("lane %0d changed its store before ready", l));
                end
                if (dmem_write_valid[l] && done) begin
                    report_failure($sformatf("lane %0d storing while done", l));
                end
                if (dmem_write_valid[l] && dmem_write_ready[l]) begin
                    record_store(int'(dmem_write_address[l]), dmem_write_data[l]);
                    dmem_write_ready[l] <= 1'b0;
                    dmem_waiting[l] = 1'b0;
                end else if (dmem_write_valid[l]) begin
                    dmem_write_ready[l] <= ready_coin[(cycle_count + 97 * (WARPS + l)) % COIN_COUNT];
                    dmem_waiting[l] = 1'b1;
                    dmem_held_address[l] = dmem_write_address[l];
                    dmem_held_data[l] = dmem_write_data[l];
                end else begin
                    dmem_write_ready[l] <= 1'b0;
                end
            end
        end
    end

    initial begin
        int fd;
        int program_lines;
        int watchdog_cycles;
        string line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;

        void'($urandom(87));
        reset = 1'b1;
        start = 1'b0;
        base_pc = '0;
        num_warps = '0;
        cfg_pc = '0;
        for (int w = 0; w < WARPS; w++) begin
            imem_ready[w] = 1'b0;
            imem_data[w] = '0;
        end
        for (int l = 0; l < THREADS; l++) begin
            dmem_write_ready[l] = 1'b0;
        end
        // roughly two ready cycles in three
        for (int i = 0; i < COIN_COUNT; i++) begin
            ready_coin[i] = ($urandom % 3) != 0;
        end

        program_lines = 0;
        fd = $fopen("test/compute_core_tests.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open test/compute_core_tests.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                // skip comments and blank lines
                if (line.len() > 1 && line.getc(0) != "#") begin
                    a = '0;
                    b = '0;
                    c = '0;
                    void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c));
                    tags.push_back(line.getc(0));
                    field_a.push_back(a);
                    field_b.push_back(b);
                    field_c.push_back(c);
                    if (line.getc(0) == "p") begin
                        program_lines++;
                    end
                end
            end
            $fclose(fd);
        end

        if (program_lines == 0) begin
            report_failure("no program lines in the test file");
        end else begin
            watchdog_cycles = CYCLES_PER_LINE * program_lines;
            fork
                begin
                    repeat (watchdog_cycles) @(posedge clk);
                    report_failure($sformatf("watchdog expired after %0d cycles", watchdog_cycles));
                    $display("errors: %0d mismatches, %0d other failures",
                             mismatch_count, failure_count);
                    $display("*** TEST FAILED ***");
                    $finish;
                end
            join_none
            for (int i = 0; i < tags.size(); i++) begin
                case (tags[i])
                    "c": begin
                        cfg_warps = int'(field_a[i]);
                        cfg_pc = gpu_pkg::imem_addr_t'(field_b[i]);
                        clear_memories();
                    end
                    "p": imem_words[field_a[i]][field_b[i]] = field_c[i];
                    "e": expected_words[int'(field_a[i])] = field_b[i];
                    default: report_failure($sformatf("unknown record %0d in test file", i));
                endcase
                // a run ends at the next config line or the end of the file
                if (i + 1 == tags.size() || tags[i + 1] == "c") begin
                    run_test();
                end
            end
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== test/compute_core_tests.txt ====
# c <num_warps> <base_pc> | p <warp> <address> <word> | e <data address> <word>
# all values hex, each c line opens a run
c 2 00
p 0 00 71000000
p 0 01 62000100
p 0 02 03210000
p 0 03 83100000
p 0 04 14210000
p 0 05 84100004
p 0 06 5510fffe
p 0 07 85100008
p 0 08 8210000c
p 0 09 81100020
p 0 0a 90000000
p 1 00 71000000
p 1 01 62000ff6
p 1 02 23210000
p 1 03 8310000c
p 1 04 34210000
p 1 05 84100010
p 1 06 45210000
p 1 07 85100014
p 1 08 81100020
p 1 09 90000000
e 00 00000100
e 01 00000101
e 02 00000102
e 03 00000103
e 04 00000100
e 05 000000ff
e 06 000000fe
e 07 000000fd
e 08 fffffffe
e 09 ffffffff
e 0a 00000000
e 0b 00000001
e 0c 00000100
e 0d 00000100
e 0e 00000100
e 0f 00000100
e 20 00000000
e 21 00000001
e 22 00000002
e 23 00000003
e 10 00000004
e 11 00000004
e 12 00000006
e 13 00000006
e 14 00000ff6
e 15 00000ff7
e 16 00000ff6
e 17 00000ff7
e 18 00000ff2
e 19 00000ff3
e 1a 00000ff0
e 1b 00000ff1
e 24 00000004
e 25 00000005
e 26 00000006
e 27 00000007
c 1 10
p 0 10 71000000
p 0 11 81100040
p 0 12 90000000
p 1 10 71000000
p 1 11 81100080
p 1 12 90000000
e 40 00000000
e 41 00000001
e 42 00000002
e 43 00000003

// ==== build.f ====
src/gpu_pkg.sv
src/imem_if.sv
src/exec_if.sv
src/fetcher.sv
src/decoder.sv
src/vector_reg_file.sv
src/lane_datapath.sv
src/warp_scheduler.sv
src/compute_core.sv
test/compute_core_asserts.sv
test/tb_compute_core.sv
